// File: verilog.f
verilog/heapPkg.sv
verilog/heapAllocator.sv
verilog/heapSizeTable.sv
verilog/heapElementStore.sv
verilog/heapControl.sv
verilog/arrayHeap.sv
dv/arrayHeapTb.sv

// File: run.sh
#!/bin/sh
# Build and run the array heap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module arrayHeapTb -f verilog.f -o arrayHeapSim

./obj_dir/arrayHeapSim

// File: dv/arrayHeapTb.sv
`timescale 1ns/1ps
/*
  Array heap testbench
  Directed tests of allocation, sizes, push and pop, element operations and timing
*/
module arrayHeapTb import heapPkg::*; ();

  localparam int clockPeriod  = 100;
  localparam int resetCycles  = 8;
  localparam int testCycles   = 100;                      // Requests and idle cycles of all tests
  localparam int marginCycles = 50;

  logic        clock, resetN, request, done;
  heapAction   action;
  arrayId      array;
  elementIndex index;
  elementData  in, out;
  heapError    error;
  logic [31:0] lfsr = 32'h01a9_6d17;

  arrayHeap i_arrayHeap (.*);

  // Clock, watchdog and helpers ---------------------
  always #(clockPeriod / 2) clock = ~clock;

  initial begin
    #((resetCycles + testCycles + marginCycles) * clockPeriod);
    reportFailure("Watchdog expired before the tests finished");
  end

  task automatic reportFailure(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkValue(string name, logic [15:0] got, logic [15:0] expected);
    assert (got === expected)
    else reportFailure($sformatf("[FAIL] %s: expected %h, got %h", name, expected, got));
  endtask

  function automatic logic [15:0] randomBits(int count);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[14:0], lfsr[0]};                     // One step per bit taken
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  // Expected element result from the operation rules
  function automatic elementData applyOp(heapAction act, elementData old, elementData data);
    case (act)
      actAdd, actAddAfter:      return old + data;        // Wraps at 16 bits
      actSubtract, actSubAfter: return old - data;
      actShiftLeft:             return (data >= 16'd16) ? '0 : old << data[3:0];
      actShiftRight:            return (data >= 16'd16) ? '0 : old >> data[3:0];
      actNotLogical:            return (old == '0) ? 16'd1 : 16'd0;
      actNot:                   return ~old;
      actOr:                    return old | data;
      actXor:                   return old ^ data;
      actAnd:                   return old & data;
      default:                  return old;
    endcase
  endfunction

  // One request, response checked in the next cycle
  task automatic issue(heapAction act, arrayId arr, elementIndex idx, elementData data,
                       elementData expOut, heapError expErr);
    request = 1'b1;
    action  = act;
    array   = arr;
    index   = idx;
    in      = data;
    @(posedge clock);
    #5;
    request = 1'b0;
    checkValue("done", 16'(done), 16'h1);
    checkValue("out", out, expOut);
    checkValue("error", 16'(error), 16'(expErr));
  endtask

  task automatic idle();
    @(posedge clock);
    #5;
    checkValue("done", 16'(done), 16'h0);                 // No request, no pulse
  endtask

  // Directed tests ----------------------------------
  task automatic testAllocation();
    for (int i = 0; i < arrayCount; i++) issue(actAlloc, '0, '0, '0, elementData'(i), errNone);
    issue(actAlloc, '0, '0, '0, '0, errOutOfMemory);
    issue(actFree, 2'd1, '0, '0, '0, errNone);
    issue(actFree, 2'd2, '0, '0, '0, errNone);
    issue(actAlloc, '0, '0, '0, 16'd2, errNone);          // Newest freed array first
    issue(actAlloc, '0, '0, '0, 16'd1, errNone);
    issue(actFree, 2'd3, '0, '0, '0, errNone);
    issue(actRead, 2'd3, '0, '0, '0, errFreed);
    issue(actReset, '0, '0, '0, '0, errNone);
    issue(actAlloc, '0, '0, '0, 16'd0, errNone);
    issue(actRead, 2'd3, '0, '0, '0, errNotAllocated);
    issue(actAlloc, '0, '0, '0, 16'd1, errNone);
    issue(actAlloc, '0, '0, '0, 16'd2, errNone);
    idle();
  endtask

  task automatic testWriteRead();
    elementData value;
    value = randomBits(dataBits);
    issue(actWrite, 2'd0, 3'd5, value, value, errNone);   // Grows the empty array to 6
    issue(actSize, 2'd0, '0, '0, 16'd6, errNone);
    issue(actRead, 2'd0, 3'd5, '0, value, errNone);
    issue(actRead, 2'd0, 3'd6, '0, '0, errOutOfBounds);
  endtask

  task automatic testPushPop();
    elementData pushed [arrayLength];
    for (int i = 0; i < arrayLength; i++) begin
      pushed[i] = randomBits(dataBits);
      issue(actPush, 2'd1, '0, pushed[i], pushed[i], errNone);
    end
    issue(actPush, 2'd1, '0, randomBits(dataBits), '0, errFull);
    for (int i = arrayLength - 1; i >= 0; i--) issue(actPop, 2'd1, '0, '0, pushed[i], errNone);
    issue(actPop, 2'd1, '0, '0, '0, errEmpty);
    issue(actInc, 2'd1, '0, '0, 16'd1, errNone);
    issue(actDec, 2'd1, '0, '0, 16'd0, errNone);
    issue(actResize, 2'd1, '0, 16'd9, '0, errTooLarge);
    issue(actResize, 2'd1, '0, 16'd3, 16'd3, errNone);
    issue(actRead, 2'd1, 3'd2, '0, pushed[2], errNone);   // Pop leaves the element in place
  endtask

  task automatic testElementOps();
    heapAction   ops [11];
    elementData  elems [arrayLength];
    elementIndex idx;
    elementData  operand, result, expOut;
    ops = '{actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft, actShiftRight,
            actNotLogical, actNot, actOr, actXor, actAnd};
    for (int i = 0; i < arrayLength; i++) begin
      elems[i] = randomBits(dataBits);
      issue(actWrite, 2'd2, elementIndex'(i), elems[i], elems[i], errNone);
    end
    for (int i = 0; i < 11; i++) begin
      idx     = elementIndex'(randomBits(indexBits));
      operand = (ops[i] inside {actShiftLeft, actShiftRight}) ? randomBits(5)
                                                              : randomBits(dataBits);
      result  = applyOp(ops[i], elems[idx], operand);
      expOut  = (ops[i] inside {actAddAfter, actSubAfter}) ? elems[idx] : result;
      issue(ops[i], 2'd2, idx, operand, expOut, errNone);
      elems[idx] = result;
      issue(actRead, 2'd2, idx, '0, result, errNone);     // Stored result, back to back
    end
    issue(actWrite, 2'd2, 3'd0, '0, '0, errNone);
    issue(actNotLogical, 2'd2, 3'd0, '0, 16'd1, errNone);
    idle();
  endtask

  task automatic testTiming();
    elementData base, step;
    base = randomBits(dataBits);
    step = randomBits(dataBits);
    issue(actWrite, 2'd0, 3'd1, base, base, errNone);
    issue(actAdd, 2'd0, 3'd1, step, base + step, errNone);
    issue(actAdd, 2'd0, 3'd1, step, base + step + step, errNone);
    idle();
    idle();
  endtask

  initial begin
    clock   = 1'b0;
    resetN  = 1'b0;
    request = 1'b0;
    action  = actRead;
    array   = '0;
    index   = '0;
    in      = '0;
    repeat (resetCycles) @(posedge clock);
    #5;
    resetN = 1'b1;
    checkValue("done", 16'(done), 16'h0);
    checkValue("out", out, 16'h0);
    checkValue("error", 16'(error), 16'(errNone));
    testAllocation();
    testWriteRead();
    testPushPop();
    testElementOps();
    testTiming();
    $display("sim passed");
    $finish;
  end

endmodule

// File: verilog/arrayHeap.sv
`timescale 1ns/1ps
/*
  Array heap top level
  Four arrays of eight elements, one request per clock, response one cycle later
*/
module arrayHeap import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        request,
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex index,
  input  elementData  in,
  output logic        done,
  output elementData  out,
  output heapError    error
);

  logic        commit;
  logic        notAllocated, freed, outOfMemory;
  arrayId      allocId;
  arraySize    currentSize;
  elementIndex pushIndex, popIndex;
  logic        outOfBounds, full, empty, tooLarge;
  elementData  oldValue, newValue;

  heapControl i_heapControl (
    .clock, .resetN, .request, .action,
    .notAllocated, .freed, .outOfMemory, .allocId, .currentSize,
    .outOfBounds, .full, .empty, .tooLarge,
    .oldValue, .newValue,
    .commit, .done, .out, .error
  );

  heapAllocator i_heapAllocator (
    .clock, .resetN, .commit, .action, .array,
    .notAllocated, .freed, .allocId, .outOfMemory
  );

  heapSizeTable i_heapSizeTable (
    .clock, .resetN, .commit, .action, .array, .index, .in, .allocId,
    .currentSize, .pushIndex, .popIndex,
    .outOfBounds, .full, .empty, .tooLarge
  );

  heapElementStore i_heapElementStore (
    .clock, .resetN, .commit, .action, .array, .index,
    .pushIndex, .popIndex, .in,
    .oldValue, .newValue
  );

endmodule

// File: verilog/heapControl.sv
`timescale 1ns/1ps
/*
  Heap control
  Ranks the fault flags, gates the commit and registers the response
*/
module heapControl import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       request,
  input  heapAction  action,
  input  logic       notAllocated,
  input  logic       freed,
  input  logic       outOfMemory,
  input  arrayId     allocId,
  input  arraySize   currentSize,
  input  logic       outOfBounds,
  input  logic       full,
  input  logic       empty,
  input  logic       tooLarge,
  input  elementData oldValue,
  input  elementData newValue,
  output logic       commit,
  output logic       done,
  output elementData out,
  output heapError   error
);

  heapError   errorNext;
  elementData outNext;
  logic       checkArray;                                 // Action names an existing array

  assign checkArray = (action != actReset) && (action != actAlloc);

  // Error priority, first match wins ----------------
  always_comb begin
    if (checkArray && notAllocated)             errorNext = errNotAllocated;
    else if (checkArray && freed)               errorNext = errFreed;
    else if (outOfBounds)                       errorNext = errOutOfBounds;
    else if (full)                              errorNext = errFull;
    else if (empty)                             errorNext = errEmpty;
    else if (tooLarge)                          errorNext = errTooLarge;
    else if (action == actAlloc && outOfMemory) errorNext = errOutOfMemory;
    else                                        errorNext = errNone;
  end

  assign commit = request && (errorNext == errNone);

  always_comb begin
    case (action)
      actWrite, actPush, actResize:              outNext = newValue;
      actRead, actPop, actAddAfter, actSubAfter: outNext = oldValue;  // Value before the op
      actSize:  outNext = elementData'(currentSize);
      actInc:   outNext = elementData'(currentSize) + 1'b1;
      actDec:   outNext = elementData'(currentSize) - 1'b1;
      actAlloc: outNext = elementData'(allocId);
      actAdd, actSubtract, actShiftLeft, actShiftRight, actNotLogical,
      actNot, actOr, actXor, actAnd:             outNext = newValue;
      default:  outNext = '0;                             // Free and Reset
    endcase
  end

  // Response register -------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done  <= 1'b0;
      out   <= '0;
      error <= errNone;
    end else begin
      done  <= request;
      out   <= commit ? outNext : '0;
      error <= request ? errorNext : errNone;
    end
  end

endmodule

// File: verilog/heapElementStore.sv
`timescale 1ns/1ps
/*
  Element store
  Holds every array's elements and performs the read-modify-write operations
*/
module heapElementStore import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        commit,
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex index,
  input  elementIndex pushIndex,
  input  elementIndex popIndex,
  input  elementData  in,
  output elementData  oldValue,
  output elementData  newValue
);

  elementData  mem [arrayCount][arrayLength];
  elementIndex slot;                                      // Element addressed this cycle
  logic        writeBack;

  always_comb begin
    case (action)
      actPush: slot = pushIndex;
      actPop:  slot = popIndex;
      default: slot = index;
    endcase
  end

  assign oldValue = mem[array][slot];

  // Operation result --------------------------------
  always_comb begin
    case (action)
      // Resize passes the requested size on as its response
      actWrite, actPush, actResize: newValue = in;
      actAdd, actAddAfter:          newValue = oldValue + in;  // Wraps at 16 bits
      actSubtract, actSubAfter:     newValue = oldValue - in;
      actShiftLeft:                 newValue = oldValue << in; // Whole of in as amount
      actShiftRight:                newValue = oldValue >> in;
      actNotLogical:                newValue = elementData'(oldValue == '0);
      actNot:                       newValue = ~oldValue;
      actOr:                        newValue = oldValue | in;
      actXor:                       newValue = oldValue ^ in;
      actAnd:                       newValue = oldValue & in;
      default:                      newValue = oldValue;
    endcase
  end

  assign writeBack = commit &&
                     (action == actWrite || action == actPush || isElementOp(action));

  always_ff @(posedge clock) begin
    if (writeBack) begin
      mem[array][slot] <= newValue;
    end
  end

endmodule

// File: verilog/heapSizeTable.sv
`timescale 1ns/1ps
/*
  Array size table
  Keeps each array's size and flags bound, full, empty and too-large faults
*/
module heapSizeTable import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        commit,
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex index,
  input  elementData  in,
  input  arrayId      allocId,
  output arraySize    currentSize,
  output elementIndex pushIndex,
  output elementIndex popIndex,
  output logic        outOfBounds,
  output logic        full,
  output logic        empty,
  output logic        tooLarge
);

  arraySize sizes [arrayCount];                           // Current size per array
  arraySize popSize;
  logic     readAccess;                                   // Request must hit a live element

  assign currentSize = sizes[array];
  assign popSize     = currentSize - 1'b1;
  assign pushIndex   = currentSize[indexBits-1:0];        // Next free slot
  assign popIndex    = popSize[indexBits-1:0];            // Last live slot

  // Fault flags -------------------------------------
  assign readAccess  = (action == actRead) || isElementOp(action);
  assign outOfBounds = readAccess && ({1'b0, index} >= currentSize);
  assign full        = (action == actPush || action == actInc) &&
                       (int'(currentSize) == arrayLength);
  assign empty       = (action == actPop || action == actDec) && (currentSize == '0);
  assign tooLarge    = (action == actResize) && (in > elementData'(arrayLength));

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      sizes <= '{default: '0};
    end else if (commit) begin
      case (action)
        actInc, actPush: sizes[array] <= currentSize + 1'b1;
        actDec, actPop:  sizes[array] <= popSize;
        actResize:       sizes[array] <= in[sizeBits-1:0];  // Bounded by tooLarge
        actAlloc:        sizes[allocId] <= '0;
        actWrite: begin
          if ({1'b0, index} >= currentSize) begin
            sizes[array] <= {1'b0, index} + 1'b1;         // Grow to cover the write
          end
        end
        default: ;
      endcase
    end
  end

  for (genvar g = 0; g < arrayCount; g++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (!resetN) int'(sizes[g]) <= arrayLength);
  end

endmodule

// File: verilog/heapAllocator.sv
`timescale 1ns/1ps
/*
  Array allocator
  Hands out arrays from a high-water count, reuses freed ones last-in first-out
*/
module heapAllocator import heapPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  logic      commit,
  input  heapAction action,
  input  arrayId    array,
  output logic      notAllocated,
  output logic      freed,
  output arrayId    allocId,
  output logic      outOfMemory
);

  logic [arrayCount-1:0] allocated;                       // One flag per array
  logic [arrayBits:0]    highWater;                       // Arrays ever handed out
  logic [arrayBits:0]    freedTop;                        // Entries on the freed stack
  logic [arrayBits-1:0]  topSlot;                         // Slot of the newest entry
  arrayId                freedStack [arrayCount];

  assign topSlot      = freedTop[arrayBits-1:0] - 1'b1;   // Wraps to the last slot when full
  assign notAllocated = {1'b0, array} >= highWater;
  assign freed        = !notAllocated && !allocated[array];
  assign allocId      = (freedTop != '0) ? freedStack[topSlot] : highWater[arrayBits-1:0];
  assign outOfMemory  = (freedTop == '0) && (int'(highWater) == arrayCount);

  // Allocation state --------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      highWater <= '0;
      freedTop  <= '0;
    end else if (commit) begin
      case (action)
        actReset: begin                                   // Forget every array
          allocated <= '0;
          highWater <= '0;
          freedTop  <= '0;
        end
        actAlloc: begin
          allocated[allocId] <= 1'b1;
          if (freedTop != '0) begin
            freedTop <= freedTop - 1'b1;                  // Reuse newest freed array
          end else begin
            highWater <= highWater + 1'b1;
          end
        end
        actFree: begin
          allocated[array] <= 1'b0;
          freedTop         <= freedTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (commit && action == actFree) begin
      freedStack[freedTop[arrayBits-1:0]] <= array;
    end
  end

  assert property (@(posedge clock) disable iff (!resetN) freedTop <= arrayCount);

  // Control must have screened the array before a Free
  assert property (@(posedge clock) disable iff (!resetN)
    commit && action == actFree |-> !notAllocated && !freed);

endmodule

// File: verilog/heapPkg.sv
/*
  Array heap shared definitions
  Sizes, element types, request action codes and error codes
*/
package heapPkg;

  // Sizes -------------------------------------------
  localparam int arrayBits   = 2;                         // Bits in an array number
  localparam int indexBits   = 3;                         // Bits in an element index
  localparam int dataBits    = 16;                        // Bits in one element
  localparam int arrayCount  = 4;                         // Arrays in the heap
  localparam int arrayLength = 8;                         // Elements per array
  localparam int sizeBits    = indexBits + 1;             // Holds 0 up to arrayLength

  typedef logic [arrayBits-1:0] arrayId;
  typedef logic [indexBits-1:0] elementIndex;
  typedef logic [dataBits-1:0]  elementData;
  typedef logic [sizeBits-1:0]  arraySize;

  // Request and response codes ----------------------
  typedef enum logic [4:0] {
    actReset = 5'd1, actWrite = 5'd2, actRead = 5'd3, actSize = 5'd4,
    actInc = 5'd5, actDec = 5'd6,
    actPush = 5'd14, actPop = 5'd15,
    actResize = 5'd17, actAlloc = 5'd18, actFree = 5'd19,
    actAdd = 5'd20, actAddAfter = 5'd21, actSubtract = 5'd22, actSubAfter = 5'd23,
    actShiftLeft = 5'd24, actShiftRight = 5'd25, actNotLogical = 5'd26,
    actNot = 5'd27, actOr = 5'd28, actXor = 5'd29, actAnd = 5'd30
  } heapAction;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                               // Above the high-water count
    errFreed        = 3'd2,
    errOutOfBounds  = 3'd3,
    errFull         = 3'd4,
    errEmpty        = 3'd5,
    errTooLarge     = 3'd6,                               // Resize beyond arrayLength
    errOutOfMemory  = 3'd7
  } heapError;

  // In-place read-modify-write operations, Add through And
  function automatic logic isElementOp(heapAction act);
    return act inside {[actAdd:actAnd]};
  endfunction

endpackage
